//--- verilog/rv32i_pkg.sv
// shared types of a reduced rv32i pipeline that has no loads, csr access, traps or compressed code
package rv32i_pkg;

  localparam int              XLEN       = 32;     // data and address width
  localparam int              REG_ADDR_W = 5;      // register index width
  localparam logic [XLEN-1:0] PC_RESET   = '0;     // first fetch address

  ////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // instruction formats
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
  } r_fmt_t;
  typedef struct packed {
    logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
  } i_fmt_t;
  typedef struct packed {
    logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;
  } s_fmt_t;
  typedef struct packed {
    logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
  } b_fmt_t;
  typedef struct packed {
    logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
  } u_fmt_t;
  typedef struct packed {
    logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
    logic [4:0] rd; logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r; i_fmt_t i; s_fmt_t s; b_fmt_t b; u_fmt_t u; j_fmt_t j;
  } instr_u;

  ////////////////////////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic valid; logic [XLEN-1:0] pc; instr_u instr;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data;   // register file values at decode
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm, use_pc, is_branch, is_jal, is_jalr, is_store;
    logic [2:0]            funct3;
  } id_ex_t;

  typedef struct packed {
    logic valid; logic [REG_ADDR_W-1:0] rd; logic rd_we; logic [XLEN-1:0] result;
    logic is_store; logic [XLEN-1:0] store_data; logic [2:0] funct3;
  } ex_mem_t;

  typedef struct packed {
    logic we; logic [REG_ADDR_W-1:0] rd; logic [XLEN-1:0] data;
  } wb_t;

  typedef struct packed {
    logic taken; logic [XLEN-1:0] target;
  } redirect_t;

endpackage

//--- verilog/rv32i_fetch.sv
// fetch with one request in flight; the memory must ack every strobe exactly once
`timescale 1ns/1ps

module rv32i_fetch
  import rv32i_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  redirect_t       i_redirect,
  input  logic            i_imem_ack,
  input  logic [XLEN-1:0] i_imem_data,
  output logic            o_imem_stb,
  output logic [XLEN-1:0] o_imem_addr,
  output if_id_t          o_if_id
);

  logic [XLEN-1:0] pc_q;
  logic            pending_q;                   // strobe sent and ack not yet seen
  logic            kill_q;                      // in-flight reply is stale after a redirect
  logic            take;

  assign o_imem_stb  = !pending_q;              // new request whenever idle
  assign o_imem_addr = pc_q;
  assign take        = i_imem_ack && !kill_q;   // reply belongs to current pc

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q      <= PC_RESET;
      pending_q <= 1'b0;
      kill_q    <= 1'b0;
    end else begin
      pending_q <= pending_q ? !i_imem_ack : 1'b1;  // strobe opens, ack closes
      if (i_redirect.taken) begin
        pc_q   <= i_redirect.target;
        kill_q <= !i_imem_ack;                  // drop the reply still to come
      end else begin
        if (take) begin
          pc_q <= pc_q + XLEN'(4);
        end
        if (i_imem_ack) begin
          kill_q <= 1'b0;                       // stale reply consumed
        end
      end
    end
  end

  // fetch/decode register, valid for one cycle per accepted reply
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_if_id <= '0;
    end else begin
      o_if_id.valid <= take && !i_redirect.taken;
      if (i_imem_ack) begin
        o_if_id.pc    <= pc_q;
        o_if_id.instr <= i_imem_data;
      end
    end
  end

endmodule

//--- verilog/rv32i_decode.sv
// decode of the supported rv32i subset; any other opcode leaves as an invalid bubble
`timescale 1ns/1ps

module rv32i_decode
  import rv32i_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  if_id_t                i_if_id,
  input  logic                  i_flush,
  output logic [REG_ADDR_W-1:0] o_rs1_addr,
  output logic [REG_ADDR_W-1:0] o_rs2_addr,
  input  logic [XLEN-1:0]       i_rs1_data,
  input  logic [XLEN-1:0]       i_rs2_data,
  output id_ex_t                o_id_ex
);

  instr_u ins;
  id_ex_t dec;
  logic   known;                                // opcode is supported

  assign ins        = i_if_id.instr;
  assign o_rs1_addr = ins.r.rs1;                // same bits in every format
  assign o_rs2_addr = ins.r.rs2;

  // alu op from funct3 and the alt bit 30
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt, input logic is_reg);
    case (f3)
      3'b000:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // control and immediate decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    dec          = '0;
    known        = 1'b1;
    dec.pc       = i_if_id.pc;
    dec.rs1_addr = ins.r.rs1;
    dec.rs2_addr = ins.r.rs2;
    dec.rs1_data = i_rs1_data;
    dec.rs2_data = i_rs2_data;
    dec.rd       = ins.r.rd;
    dec.funct3   = ins.r.funct3;
    dec.alu_op   = ALU_ADD;
    case (ins.r.opcode)
      OPC_OP: begin
        dec.rd_we  = 1'b1;
        dec.alu_op = alu_sel(ins.r.funct3, ins.r.funct7[5], 1'b1);
      end
      OPC_OP_IMM: begin
        dec.rd_we   = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = {{20{ins.i.imm[11]}}, ins.i.imm};
        dec.alu_op  = alu_sel(ins.r.funct3, ins.r.funct7[5], 1'b0);
      end
      OPC_LUI, OPC_AUIPC: begin
        dec.rd_we   = 1'b1;
        dec.use_imm = 1'b1;
        dec.use_pc  = (ins.u.opcode == OPC_AUIPC);  // auipc adds to pc
        dec.imm     = {ins.u.imm_31_12, 12'b0};
        dec.alu_op  = dec.use_pc ? ALU_ADD : ALU_PASS_B;
      end
      OPC_JAL: begin
        dec.rd_we  = 1'b1;
        dec.is_jal = 1'b1;
        dec.imm    = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12,
                      ins.j.imm_11, ins.j.imm_10_1, 1'b0};
      end
      OPC_JALR: begin
        dec.rd_we   = 1'b1;
        dec.is_jalr = 1'b1;
        dec.imm     = {{20{ins.i.imm[11]}}, ins.i.imm};
      end
      OPC_BRANCH: begin
        dec.is_branch = 1'b1;
        known         = (ins.b.funct3[2:1] != 2'b01);  // 010 and 011 unused
        dec.imm       = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
                         ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
      end
      OPC_STORE: begin
        dec.is_store = 1'b1;
        dec.use_imm  = 1'b1;                    // address is rs1 plus imm
        known        = !ins.s.funct3[2] && (ins.s.funct3[1:0] != 2'b11);  // sb sh sw only
        dec.imm      = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
      end
      default: known = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_id_ex <= '0;
    end else begin
      o_id_ex       <= dec;
      o_id_ex.valid <= i_if_id.valid && known && !i_flush;
    end
  end

endmodule

//--- verilog/rv32i_regfile.sv
// 31 writable registers with x0 fixed at zero and same-cycle write to read bypass
`timescale 1ns/1ps

module rv32i_regfile
  import rv32i_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [REG_ADDR_W-1:0] i_rs2_addr,
  input  wb_t                   i_wb,
  output logic [XLEN-1:0]       o_rs1_data,
  output logic [XLEN-1:0]       o_rs2_data
);

  logic [XLEN-1:0] regs [1:31];                 // no storage for x0

  function automatic logic [XLEN-1:0] rd_port(input logic [REG_ADDR_W-1:0] addr);
    if (addr == '0) return '0;
    if (i_wb.we && i_wb.rd == addr) return i_wb.data;  // write through
    return regs[addr];
  endfunction

  always_comb begin
    o_rs1_data = rd_port(i_rs1_addr);
    o_rs2_data = rd_port(i_rs2_addr);
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.we && i_wb.rd != '0) begin
      regs[i_wb.rd] <= i_wb.data;               // x0 writes dropped
    end
  end

endmodule

//--- verilog/rv32i_forward.sv
// operand bypass into execute; every result is ready in ex_mem so no stall is needed
`timescale 1ns/1ps

module rv32i_forward
  import rv32i_pkg::*;
(
  input  id_ex_t          i_id_ex,
  input  ex_mem_t         i_ex_mem,
  input  wb_t             i_wb,
  output logic [XLEN-1:0] o_op_a,
  output logic [XLEN-1:0] o_op_b
);

  // newest producer wins
  function automatic logic [XLEN-1:0] pick(input logic [REG_ADDR_W-1:0] rs,
                                           input logic [XLEN-1:0]       rf_val);
    if (rs == '0) return rf_val;                // x0 never forwarded
    if (i_ex_mem.valid && i_ex_mem.rd_we && i_ex_mem.rd == rs) return i_ex_mem.result;
    if (i_wb.we && i_wb.rd == rs) return i_wb.data;
    return rf_val;                              // value read in decode
  endfunction

  always_comb begin
    o_op_a = pick(i_id_ex.rs1_addr, i_id_ex.rs1_data);
    o_op_b = pick(i_id_ex.rs2_addr, i_id_ex.rs2_data);
  end

endmodule

//--- verilog/rv32i_execute.sv
// alu and branch resolution; a taken branch or jump redirects fetch in the same cycle
`timescale 1ns/1ps

module rv32i_execute
  import rv32i_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  id_ex_t          i_id_ex,
  input  logic [XLEN-1:0] i_op_a,
  input  logic [XLEN-1:0] i_op_b,
  output redirect_t       o_redirect,
  output ex_mem_t         o_ex_mem
);

  logic [XLEN-1:0] src_a, src_b;
  logic [XLEN-1:0] alu_y;
  logic [4:0]      shamt;
  logic            cond;                        // branch condition met
  logic            is_jump;

  assign src_a   = i_id_ex.use_pc ? i_id_ex.pc : i_op_a;
  assign src_b   = i_id_ex.use_imm ? i_id_ex.imm : i_op_b;
  assign shamt   = src_b[4:0];
  assign is_jump = i_id_ex.is_jal || i_id_ex.is_jalr;

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (i_id_ex.alu_op)
      ALU_ADD:    alu_y = src_a + src_b;
      ALU_SUB:    alu_y = src_a - src_b;
      ALU_SLL:    alu_y = src_a << shamt;
      ALU_SLT:    alu_y = XLEN'($signed(src_a) < $signed(src_b));
      ALU_SLTU:   alu_y = XLEN'(src_a < src_b);
      ALU_XOR:    alu_y = src_a ^ src_b;
      ALU_SRL:    alu_y = src_a >> shamt;
      ALU_SRA:    alu_y = $signed(src_a) >>> shamt;
      ALU_OR:     alu_y = src_a | src_b;
      ALU_AND:    alu_y = src_a & src_b;
      ALU_PASS_B: alu_y = src_b;                // lui
      default:    alu_y = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // branch compare and redirect
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (i_id_ex.funct3)
      3'b000:  cond = (i_op_a == i_op_b);                      // beq
      3'b001:  cond = (i_op_a != i_op_b);                      // bne
      3'b100:  cond = ($signed(i_op_a) < $signed(i_op_b));     // blt
      3'b101:  cond = ($signed(i_op_a) >= $signed(i_op_b));    // bge
      3'b110:  cond = (i_op_a < i_op_b);                       // bltu
      3'b111:  cond = (i_op_a >= i_op_b);                      // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign o_redirect.taken  = i_id_ex.valid && (is_jump || (i_id_ex.is_branch && cond));
  assign o_redirect.target = i_id_ex.is_jalr ?
                             ((i_op_a + i_id_ex.imm) & ~XLEN'(1)) :  // jalr clears bit 0
                             (i_id_ex.pc + i_id_ex.imm);

  // execute/memory register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ex_mem <= '0;
    end else begin
      o_ex_mem.valid      <= i_id_ex.valid;
      o_ex_mem.rd         <= i_id_ex.rd;
      o_ex_mem.rd_we      <= i_id_ex.rd_we;
      o_ex_mem.result     <= is_jump ? i_id_ex.pc + XLEN'(4) : alu_y;  // link or alu/address
      o_ex_mem.is_store   <= i_id_ex.is_store;
      o_ex_mem.store_data <= i_op_b;            // forwarded rs2
      o_ex_mem.funct3     <= i_id_ex.funct3;
    end
  end

endmodule

//--- verilog/rv32i_memwb.sv
// store port and register write; every store strobe must be accepted in its cycle
`timescale 1ns/1ps

module rv32i_memwb
  import rv32i_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  ex_mem_t         i_ex_mem,
  output logic            o_dmem_stb,
  output logic [XLEN-1:0] o_dmem_addr,
  output logic [XLEN-1:0] o_dmem_wdata,
  output logic [3:0]      o_dmem_sel,
  output wb_t             o_wb
);

  logic [XLEN-1:0] lane_data;                   // store data replicated per lane
  logic [3:0]      lane_sel;
  logic [1:0]      ofs;

  assign ofs = i_ex_mem.result[1:0];

  always_comb begin
    case (i_ex_mem.funct3[1:0])
      2'b00: begin                              // sb
        lane_data = {4{i_ex_mem.store_data[7:0]}};
        lane_sel  = 4'b0001 << ofs;
      end
      2'b01: begin                              // sh
        lane_data = {2{i_ex_mem.store_data[15:0]}};
        lane_sel  = ofs[1] ? 4'b1100 : 4'b0011;
      end
      default: begin                            // sw
        lane_data = i_ex_mem.store_data;
        lane_sel  = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dmem_stb <= 1'b0;
      o_wb       <= '0;
    end else begin
      o_dmem_stb <= i_ex_mem.valid && i_ex_mem.is_store;
      o_wb.we    <= i_ex_mem.valid && i_ex_mem.rd_we && !i_ex_mem.is_store;
      o_wb.rd    <= i_ex_mem.rd;
      o_wb.data  <= i_ex_mem.result;
    end
  end

  always_ff @(posedge i_clk) begin
    o_dmem_addr  <= {i_ex_mem.result[XLEN-1:2], 2'b00};  // word aligned
    o_dmem_wdata <= lane_data;
    o_dmem_sel   <= lane_sel;
  end

endmodule

//--- verilog/rv32i_core.sv
// four-stage rv32i core without loads or traps; the store port has no back-pressure
`timescale 1ns/1ps

module rv32i_core
  import rv32i_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst_n,
  output logic            o_imem_stb,     // one-cycle fetch request
  output logic [XLEN-1:0] o_imem_addr,
  input  logic            i_imem_ack,     // ends the outstanding fetch
  input  logic [XLEN-1:0] i_imem_data,
  output logic            o_dmem_stb,     // one-cycle store strobe
  output logic [XLEN-1:0] o_dmem_addr,
  output logic [XLEN-1:0] o_dmem_wdata,
  output logic [3:0]      o_dmem_sel
);

  if_id_t                if_id;
  id_ex_t                id_ex;
  ex_mem_t               ex_mem;
  wb_t                   wb;
  redirect_t             redirect;
  logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [XLEN-1:0]       rs1_data, rs2_data;
  logic [XLEN-1:0]       op_a, op_b;            // forwarded operands

  rv32i_fetch u_fetch (
    .i_clk, .i_rst_n,
    .i_redirect  (redirect),                    // taken branch or jump from execute
    .i_imem_ack, .i_imem_data, .o_imem_stb, .o_imem_addr,
    .o_if_id     (if_id)
  );

  rv32i_decode u_decode (
    .i_clk, .i_rst_n,
    .i_if_id     (if_id),
    .i_flush     (redirect.taken),              // kills the instruction in decode
    .o_rs1_addr  (rs1_addr), .o_rs2_addr (rs2_addr),
    .i_rs1_data  (rs1_data), .i_rs2_data (rs2_data),
    .o_id_ex     (id_ex)
  );

  rv32i_regfile u_regfile (
    .i_clk, .i_rst_n,
    .i_rs1_addr  (rs1_addr), .i_rs2_addr (rs2_addr),
    .i_wb        (wb),                          // write port from memwb
    .o_rs1_data  (rs1_data), .o_rs2_data (rs2_data)
  );

  rv32i_forward u_forward (
    .i_id_ex (id_ex), .i_ex_mem (ex_mem), .i_wb (wb),
    .o_op_a  (op_a),  .o_op_b   (op_b)
  );

  rv32i_execute u_execute (
    .i_clk, .i_rst_n,
    .i_id_ex (id_ex), .i_op_a (op_a), .i_op_b (op_b),
    .o_redirect (redirect), .o_ex_mem (ex_mem)
  );

  rv32i_memwb u_memwb (
    .i_clk, .i_rst_n,
    .i_ex_mem (ex_mem),
    .o_dmem_stb, .o_dmem_addr, .o_dmem_wdata, .o_dmem_sel,
    .o_wb     (wb)
  );

endmodule

//--- test/rv32i_assertions.sv
// fetch and store protocol checks bound into rv32i_core; assumes one ack per fetch strobe
`timescale 1ns/1ps

module rv32i_assertions
  import rv32i_pkg::*;
(
  input logic            i_clk,
  input logic            i_rst_n,
  input logic            i_imem_stb,
  input logic [XLEN-1:0] i_imem_addr,
  input logic            i_imem_ack,
  input logic            i_dmem_stb,
  input logic [3:0]      i_dmem_sel
);

  int unsigned fail_count = 0;                  // failed checks so far
  logic        seen_stb;                        // first fetch already issued
  logic        outstanding;                     // strobe sent, ack still to come

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      seen_stb    <= 1'b0;
      outstanding <= 1'b0;
    end else begin
      seen_stb <= seen_stb || i_imem_stb;
      if (i_imem_stb) begin
        outstanding <= 1'b1;
      end else if (i_imem_ack) begin
        outstanding <= 1'b0;                    // reply closes the request
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // reset
  ////////////////////////////////////////////////////////////
  a_reset_quiet: assert property (@(posedge i_clk) (!i_rst_n || !$past(i_rst_n)) |-> !i_dmem_stb)
    else begin
      $error("store strobe is high during reset or at its release");
      fail_count++;
    end

  a_first_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                 (i_imem_stb && !seen_stb) |-> i_imem_addr == PC_RESET)
    else begin
      $error("first fetch after reset is not at the reset address");
      fail_count++;
    end

  ////////////////////////////////////////////////////////////
  // fetch and store port
  ////////////////////////////////////////////////////////////
  a_one_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                      outstanding |-> !i_imem_stb)
    else begin
      $error("new fetch strobe while a request is still outstanding");
      fail_count++;
    end

  a_fetch_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                    i_imem_stb |-> i_imem_addr[1:0] == 2'b00)
    else begin
      $error("fetch address is not word aligned");
      fail_count++;
    end

  a_sel_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                  i_dmem_stb |-> i_dmem_sel != 4'b0000)
    else begin
      $error("store strobe with no byte selected");
      fail_count++;
    end

endmodule

bind rv32i_core rv32i_assertions u_assertions (
  .i_clk, .i_rst_n,
  .i_imem_stb (o_imem_stb), .i_imem_addr (o_imem_addr), .i_imem_ack,
  .i_dmem_stb (o_dmem_stb), .i_dmem_sel (o_dmem_sel)
);

//--- test/tb_rv32i_core.sv
// fixed program from a rom that answers each fetch after 1 to 4 cycles; stores are checked in order
`timescale 1ns/1ps

module tb_rv32i_core
  import rv32i_pkg::*;
();

  logic            clk       = 1'b0;
  logic            rst_n     = 1'b0;
  logic            imem_ack  = 1'b0;
  logic [XLEN-1:0] imem_data = '0;
  logic            imem_stb, dmem_stb;
  logic [XLEN-1:0] imem_addr, dmem_addr, dmem_wdata;
  logic [3:0]      dmem_sel;

  logic [31:0]     rom [0:63];                  // instruction words by word address
  logic [15:0]     lfsr_state     = 16'd31945;
  logic            busy           = 1'b0;       // rom working on a request
  logic [XLEN-1:0] req_addr       = '0;
  logic [3:0]      wait_left      = '0;
  int              rst_cycles     = 0;
  int              fetch_count    = 0;
  int              spin_fetches   = 0;          // fetches of the closing self jump
  logic [31:0]     exp_addr [$];
  logic [31:0]     exp_data [$];
  logic [3:0]      exp_sel  [$];
  int              store_idx      = 0;
  int              check_errors   = 0;
  int              timeout_errors = 0;

  rv32i_core i_dut (
    .i_clk        (clk),        .i_rst_n     (rst_n),
    .o_imem_stb   (imem_stb),   .o_imem_addr (imem_addr),
    .i_imem_ack   (imem_ack),   .i_imem_data (imem_data),
    .o_dmem_stb   (dmem_stb),   .o_dmem_addr (dmem_addr),
    .o_dmem_wdata (dmem_wdata), .o_dmem_sel  (dmem_sel)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[k]       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);       // one step per bit
    end
  endtask

  task automatic expect_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    exp_addr.push_back(a);
    exp_data.push_back(d);
    exp_sel.push_back(s);
  endtask

  ////////////////////////////////////////////////////////////
  // program and expected stores
  ////////////////////////////////////////////////////////////
  task automatic load_program();
    for (int i = 0; i < 64; i++) begin
      rom[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, OPC_OP_IMM);   // nop tagged with its index
    end
    rom[0]  = i_type(12'h123, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);   // addi x1, x0, 0x123
    rom[1]  = r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd2);           // add  x2, x1, x1
    rom[2]  = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3);           // sub  x3, x1, x2
    rom[3]  = r_type(7'h00, 5'd2, 5'd3, 3'b100, 5'd4);           // xor  x4, x3, x2
    rom[4]  = r_type(7'h00, 5'd1, 5'd4, 3'b001, 5'd5);           // sll  x5, x4, x1
    rom[5]  = r_type(7'h20, 5'd1, 5'd5, 3'b101, 5'd6);           // sra  x6, x5, x1
    rom[6]  = r_type(7'h00, 5'd6, 5'd1, 3'b011, 5'd7);           // sltu x7, x1, x6
    rom[7]  = s_type(12'h100, 5'd6, 5'd0, 3'b010);               // sw x6
    rom[8]  = s_type(12'h104, 5'd7, 5'd0, 3'b010);               // sw x7
    rom[9]  = b_type(13'd8, 5'd1, 5'd1, 3'b000);                 // beq taken
    rom[10] = s_type(12'h1F0, 5'd1, 5'd0, 3'b010);               // skipped
    rom[11] = b_type(13'd8, 5'd2, 5'd1, 3'b001);                 // bne taken
    rom[12] = s_type(12'h1F4, 5'd1, 5'd0, 3'b010);               // skipped
    rom[13] = b_type(13'd8, 5'd1, 5'd3, 3'b100);                 // blt x3 < x1 taken
    rom[14] = s_type(12'h1F8, 5'd1, 5'd0, 3'b010);               // skipped
    rom[15] = b_type(13'd8, 5'd2, 5'd1, 3'b111);                 // bgeu not taken
    rom[16] = s_type(12'h108, 5'd2, 5'd0, 3'b010);               // sw x2 on the fall through
    rom[17] = j_type(21'd12, 5'd8);                              // jal x8 to word 20
    rom[18] = s_type(12'h1FC, 5'd1, 5'd0, 3'b010);               // skipped
    rom[19] = s_type(12'h1FC, 5'd1, 5'd0, 3'b010);               // skipped
    rom[20] = s_type(12'h10C, 5'd8, 5'd0, 3'b010);               // sw link of jal
    rom[21] = i_type(12'd21, 5'd8, 3'b000, 5'd9, OPC_JALR);      // jalr x9, 21(x8) to word 23
    rom[22] = s_type(12'h1FC, 5'd1, 5'd0, 3'b010);               // skipped
    rom[23] = s_type(12'h110, 5'd9, 5'd0, 3'b010);               // sw link of jalr
    rom[24] = u_type(20'h12345, 5'd10, OPC_LUI);                 // lui  x10
    rom[25] = i_type(12'h678, 5'd10, 3'b000, 5'd10, OPC_OP_IMM); // x10 = 0x12345678
    for (int k = 0; k < 4; k++) begin
      rom[26 + k] = s_type(12'h200 + 12'(k), 5'd10, 5'd0, 3'b000);  // sb at each offset
    end
    rom[30] = s_type(12'h204, 5'd10, 5'd0, 3'b001);              // sh low half
    rom[31] = s_type(12'h206, 5'd10, 5'd0, 3'b001);              // sh high half
    rom[32] = s_type(12'h208, 5'd10, 5'd0, 3'b010);              // sw
    rom[33] = i_type(12'h055, 5'd0, 3'b000, 5'd0, OPC_OP_IMM);   // addi to x0 is dropped
    rom[34] = s_type(12'h20C, 5'd0, 5'd0, 3'b010);               // sw x0
    rom[35] = j_type(21'd0, 5'd0);                               // spin here
  endtask

  task automatic build_expected();
    logic [31:0] x1, x2, x3, x4, x5, x6, x7, x10;
    x1  = 32'h123;
    x2  = x1 + x1;
    x3  = x1 - x2;
    x4  = x3 ^ x2;
    x5  = x4 << x1[4:0];
    x6  = $signed(x5) >>> x1[4:0];
    x7  = {31'b0, x1 < x6};
    x10 = 32'h1234_5678;
    expect_store(32'h100, x6, 4'hF);
    expect_store(32'h104, x7, 4'hF);
    expect_store(32'h108, x2, 4'hF);
    expect_store(32'h10C, 32'd17 * 4 + 4, 4'hF);               // jal pc plus four
    expect_store(32'h110, 32'd21 * 4 + 4, 4'hF);               // jalr pc plus four
    for (int k = 0; k < 4; k++) begin
      expect_store(32'h200, {4{x10[7:0]}}, 4'b0001 << k);
    end
    expect_store(32'h204, {2{x10[15:0]}}, 4'b0011);
    expect_store(32'h204, {2{x10[15:0]}}, 4'b1100);
    expect_store(32'h208, x10, 4'hF);
    expect_store(32'h20C, 32'h0, 4'hF);
  endtask

  ////////////////////////////////////////////////////////////
  // reset and rom model
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin : rom_model
    logic [3:0] dly;
    imem_ack = 1'b0;
    if (!rst_n) begin
      rst_cycles++;
      rst_n = (rst_cycles >= 4);                // release after four cycles
    end
    if (rst_n) begin
      if (busy) begin
        if (wait_left == 4'd1) begin
          imem_ack  = 1'b1;
          imem_data = rom[req_addr[7:2]];
          busy      = 1'b0;
        end else begin
          wait_left = wait_left - 4'd1;
        end
      end else if (imem_stb) begin
        random_bits(2, dly);
        req_addr  = imem_addr;
        wait_left = dly + 4'd1;                 // 1 to 4 cycles
        busy      = 1'b1;
        fetch_count++;
        if (rom[imem_addr[7:2]] == j_type(21'd0, 5'd0)) begin
          spin_fetches++;                       // closing self jump fetched
        end
      end
    end
  end

  // store monitor
  always @(negedge clk) begin
    if (dmem_stb) begin
      assert (store_idx < exp_addr.size()) else begin
        $display("unexpected store to address %h after the last expected store", dmem_addr);
        check_errors++;
      end
      if (store_idx < exp_addr.size()) begin
        assert (dmem_addr == exp_addr[store_idx]) else begin
          $display("mismatch o_dmem_addr at store %0d: got %h, expected %h",
                   store_idx, dmem_addr, exp_addr[store_idx]);
          check_errors++;
        end
        assert (dmem_wdata == exp_data[store_idx]) else begin
          $display("mismatch o_dmem_wdata at store %0d: got %h, expected %h",
                   store_idx, dmem_wdata, exp_data[store_idx]);
          check_errors++;
        end
        assert (dmem_sel == exp_sel[store_idx]) else begin
          $display("mismatch o_dmem_sel at store %0d: got %h, expected %h",
                   store_idx, dmem_sel, exp_sel[store_idx]);
          check_errors++;
        end
      end
      store_idx++;
    end
  end

  initial begin : main
    int cyc;
    load_program();
    build_expected();
    cyc = 0;
    while (fetch_count == 0 && cyc < 20) begin
      @(posedge clk);
      cyc++;
    end
    if (fetch_count == 0) begin
      $display("timeout: the core issued no fetch strobe after reset");
      timeout_errors++;
    end
    cyc = 0;
    while (store_idx < exp_addr.size() && cyc < 2000) begin
      @(posedge clk);
      cyc++;
    end
    if (store_idx < exp_addr.size()) begin
      $display("timeout: only %0d of %0d expected stores were seen", store_idx, exp_addr.size());
      timeout_errors++;
    end
    cyc = 0;
    while (spin_fetches < 3 && cyc < 200) begin  // self jump run twice so trailing stores show
      @(posedge clk);
      cyc++;
    end
    if (spin_fetches < 3) begin
      $display("timeout: the core never settled in the closing self jump");
      timeout_errors++;
    end
    $display("errors: %0d store checks, %0d assertions, %0d timeouts",
             check_errors, i_dut.u_assertions.fail_count, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0 && i_dut.u_assertions.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/rv32i_pkg.sv
verilog/rv32i_fetch.sv
verilog/rv32i_decode.sv
verilog/rv32i_regfile.sv
verilog/rv32i_forward.sv
verilog/rv32i_execute.sv
verilog/rv32i_memwb.sv
verilog/rv32i_core.sv
test/rv32i_assertions.sv
test/tb_rv32i_core.sv

//--- run.sh
#!/bin/sh
# build and run the rv32i_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --assert -j 0 --top-module tb_rv32i_core -f verilog.f -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "compile failed"
  exit 1
fi

./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0
